// File: source/m68kDram_macros.svh
// timing and init constants for the 68000 SDRAM controller
// power-up wait, refresh reload, init loop counts, mode register value
`ifndef M68KDRAM_MACROS_SVH
`define M68KDRAM_MACROS_SVH

////////////////////////////// power-up
`define PowerUpDelay 7 // clocks with CKE low, short for simulation

////////////////////////////// refresh
`define RefreshInterval 16'h0176 // refresh timer reload
`define InitRefreshCount 10 // auto-refreshes during init
`define RefreshNopCount 3 // NOPs after each auto-refresh

////////////////////////////// mode register
`define ModeNopCount 3 // NOPs after mode register load
`define CasLatency 2 // read data delay in clocks
`define ModeRegisterValue 13'h220 // burst 1, CL2, single write

////////////////////////////// timers
`define TimerWidth 16 // width of delay and refresh counters

`endif

// File: source/sdramPkg.sv
// SDRAM side types
// command encoding, A bus with row and column views, registered pin bundle
package sdramPkg;

	// {CKE, CS_L, RAS_L, CAS_L, WE_L}
	typedef enum logic [4:0] {
		PowerUp = 5'b00000, // CKE and CS low while supply settles
		Nop = 5'b10111,
		Activate = 5'b10011, // bank and row on BA and A
		Read = 5'b10101, // A10 high selects auto-precharge
		Write = 5'b10100, // A10 high selects auto-precharge
		Precharge = 5'b10010, // A10 high means all banks
		AutoRefresh = 5'b10001,
		ModeSet = 5'b10000 // mode word on A
	} sdramCmd;

	// A bus is a row during activate, a column plus A10 during read and write
	typedef union packed {
		logic [12:0] rowView; // full row address
		struct packed {
			logic [1:0] spare; // A12..A11, unused for columns
			logic autoPrecharge; // A10
			logic [9:0] column; // A9..A0
		} colView;
	} sdramAddr;

	typedef struct packed {
		sdramCmd cmd; // 5 bit command
		sdramAddr addr; // 13 bit A bus
		logic [1:0] bank; // BA1..BA0
	} sdramPins;

endpackage

// File: source/cpuBusPkg.sv
// 68000 side types
// CPU address field layout and the bundled bus inputs
package cpuBusPkg;

	// 32 bit word address split into SDRAM coordinates
	typedef struct packed {
		logic [5:0] unused; // 31..26
		logic [1:0] bank; // 25..24
		logic [12:0] row; // 23..11
		logic [9:0] column; // 10..1
		logic byteLane; // A0, not driven by a 68000
	} cpuAddr;

	typedef struct packed {
		cpuAddr addr;
		logic [15:0] dataIn; // write data from CPU
		logic upperStrobe_L; // UDS
		logic lowerStrobe_L; // LDS
		logic select_L; // DRAM address decode
		logic write_L; // low for write, high for read
		logic addrStrobe_L; // AS
	} cpuBus;

endpackage

// File: source/sdramTimers.sv
// delay timer for power-up and CAS wait
// refresh interval timer reloaded with the refresh period
`timescale 1ns/1ps
`include "m68kDram_macros.svh"

module sdramTimers (
	input logic Clock,
	input logic Reset_L,
	input logic delayLoad, // load delayValue on next edge
	input logic [`TimerWidth-1:0] delayValue,
	input logic refreshLoad, // restart the refresh period
	output logic delayDone, // delay counter at zero
	output logic refreshDue // refresh counter at zero
);

	logic [`TimerWidth-1:0] delayCount;
	logic [`TimerWidth-1:0] refreshCount;

	////////////////////////////// delay counter
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			delayCount <= '0;
		end else if (delayLoad) begin
			delayCount <= delayValue;
		end else if (delayCount != '0) begin
			delayCount <= delayCount - 1'b1; // stops at zero
		end
	end

	assign delayDone = (delayCount == '0);

	////////////////////////////// refresh counter
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			refreshCount <= '0;
		end else if (refreshLoad) begin
			refreshCount <= `RefreshInterval;
		end else if (refreshCount != '0) begin
			refreshCount <= refreshCount - 1'b1;
		end
	end

	assign refreshDue = (refreshCount == '0);

	// a new period starts only once the previous one has run out
	refreshLoadWhenDue: assert property (@(posedge Clock) disable iff (!Reset_L)
		refreshLoad |-> refreshDue);

endmodule

// File: source/dramSequencer.sv
// main controller FSM for the 68000 SDRAM interface
// init sequence, periodic refresh and single-word access
// NOP and refresh loop counters, SDRAM address build from the CPU address
`timescale 1ns/1ps
`include "m68kDram_macros.svh"

module dramSequencer (
	input logic Clock,
	input logic Reset_L,
	input cpuBusPkg::cpuBus Bus,
	input logic delayDone,
	input logic refreshDue,
	output logic delayLoad,
	output logic [`TimerWidth-1:0] delayValue,
	output logic refreshLoad,
	output sdramPkg::sdramPins nextPins, // registered by the phy
	output logic writeEnable, // drive DQ next cycle
	output logic [15:0] writeData,
	output logic latchRead, // take DQ on this falling edge
	output logic ackNext, // Dtack low next cycle
	output logic initDone
);

	typedef enum logic [4:0] {
		InitStart, PowerWait, FirstNop, InitPrecharge, InitPrechargeNop,
		InitRefresh, InitRefreshNop, ModeLoad, ModeNop, LoadRefresh,
		Idle, RefPrecharge, RefPrechargeNop, RefRefresh, RefNop,
		RowOpen, WriteCmd, WriteHold, ReadCmd, CasWait, Terminate
	} seqState;

	localparam logic [12:0] PrechargeAllAddr = 13'h0400; // A10 high selects every bank

	seqState state;
	seqState nextState;
	logic [3:0] nopCount; // NOPs left after refresh or mode load
	logic [3:0] refreshCount; // init auto-refreshes left
	logic strobeLow; // either data strobe active
	sdramPkg::sdramAddr rowAddr;
	sdramPkg::sdramAddr colAddr;

	assign strobeLow = !Bus.upperStrobe_L || !Bus.lowerStrobe_L;

	////////////////////////////// address views
	always_comb begin
		rowAddr.rowView = Bus.addr.row; // A23..A11
		colAddr.colView.spare = 2'b00;
		colAddr.colView.autoPrecharge = 1'b1; // every access closes its row
		colAddr.colView.column = Bus.addr.column; // A10..A1
	end

	////////////////////////////// state and loop counters
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state <= InitStart;
			nopCount <= '0;
			refreshCount <= '0;
			initDone <= 1'b0;
		end else begin
			state <= nextState;
			case (state)
				InitPrechargeNop: refreshCount <= 4'(`InitRefreshCount);
				InitRefresh: begin
					nopCount <= 4'(`RefreshNopCount);
					refreshCount <= refreshCount - 4'd1;
				end
				RefRefresh: nopCount <= 4'(`RefreshNopCount);
				ModeLoad: nopCount <= 4'(`ModeNopCount);
				InitRefreshNop, ModeNop, RefNop: nopCount <= nopCount - 4'd1;
				LoadRefresh: initDone <= 1'b1; // releases CPU reset
				default: ;
			endcase
		end
	end

	////////////////////////////// next state and outputs
	always_comb begin
		nextState = state;
		nextPins.cmd = sdramPkg::Nop; // default command
		nextPins.addr = '0;
		nextPins.bank = 2'b00;
		delayLoad = 1'b0;
		delayValue = '0;
		refreshLoad = 1'b0;
		writeEnable = 1'b0;
		writeData = '0;
		latchRead = 1'b0;
		ackNext = 1'b0;

		case (state)
			InitStart: begin
				nextPins.cmd = sdramPkg::PowerUp;
				delayLoad = 1'b1;
				delayValue = `TimerWidth'(`PowerUpDelay);
				nextState = PowerWait;
			end
			PowerWait: begin
				nextPins.cmd = sdramPkg::PowerUp; // CKE low until delay ends
				if (delayDone) nextState = FirstNop;
			end
			FirstNop: nextState = InitPrecharge;
			InitPrecharge: begin
				nextPins.cmd = sdramPkg::Precharge;
				nextPins.addr = PrechargeAllAddr;
				nextState = InitPrechargeNop;
			end
			InitPrechargeNop: nextState = InitRefresh;
			InitRefresh: begin
				nextPins.cmd = sdramPkg::AutoRefresh;
				nextState = InitRefreshNop;
			end
			InitRefreshNop: begin
				if (nopCount == 4'd1) begin
					nextState = (refreshCount != '0) ? InitRefresh : ModeLoad;
				end
			end
			ModeLoad: begin
				nextPins.cmd = sdramPkg::ModeSet;
				nextPins.addr.rowView = `ModeRegisterValue;
				nextState = ModeNop;
			end
			ModeNop: if (nopCount == 4'd1) nextState = LoadRefresh;
			LoadRefresh: begin
				refreshLoad = 1'b1; // first refresh period
				nextState = Idle;
			end
			Idle: begin
				if (refreshDue) begin
					nextState = RefPrecharge; // refresh wins over access
				end else if (!Bus.select_L && !Bus.addrStrobe_L) begin
					nextState = RowOpen;
				end
			end
			RefPrecharge: begin
				nextPins.cmd = sdramPkg::Precharge;
				nextPins.addr = PrechargeAllAddr;
				nextState = RefPrechargeNop;
			end
			RefPrechargeNop: nextState = RefRefresh;
			RefRefresh: begin
				nextPins.cmd = sdramPkg::AutoRefresh;
				nextState = RefNop;
			end
			RefNop: begin
				if (nopCount == 4'd1) begin
					refreshLoad = 1'b1; // next period starts now
					nextState = Idle;
				end
			end
			RowOpen: begin
				nextPins.cmd = sdramPkg::Activate;
				nextPins.addr = rowAddr;
				nextPins.bank = Bus.addr.bank;
				nextState = Bus.write_L ? ReadCmd : WriteCmd;
			end
			WriteCmd: begin
				if (strobeLow) begin // data valid once a strobe falls
					nextPins.cmd = sdramPkg::Write;
					nextPins.addr = colAddr;
					nextPins.bank = Bus.addr.bank;
					writeEnable = 1'b1;
					writeData = Bus.dataIn;
					nextState = WriteHold;
				end
			end
			WriteHold: begin
				writeEnable = 1'b1; // DQ held a second cycle
				writeData = Bus.dataIn;
				ackNext = 1'b1;
				nextState = Terminate;
			end
			ReadCmd: begin
				nextPins.cmd = sdramPkg::Read;
				nextPins.addr = colAddr;
				nextPins.bank = Bus.addr.bank;
				delayLoad = 1'b1;
				delayValue = `TimerWidth'(`CasLatency);
				nextState = CasWait;
			end
			CasWait: begin
				if (delayDone) begin
					latchRead = 1'b1; // data latched before Dtack falls
					ackNext = 1'b1;
					nextState = Terminate;
				end
			end
			Terminate: begin
				if (strobeLow) begin
					ackNext = 1'b1; // hold Dtack while CPU holds strobes
				end else begin
					nextState = Idle;
				end
			end
			default: nextState = Idle;
		endcase
	end

	// Dtack to the CPU only after init has released its reset
	ackAfterInit: assert property (@(posedge Clock) disable iff (!Reset_L)
		ackNext |-> initDone);

	// DQ still driven the cycle after writeEnable drops
	noReadWhileDriving: assert property (@(posedge Clock) disable iff (!Reset_L)
		nextPins.cmd == sdramPkg::Read |-> !writeEnable && !$past(writeEnable));

endmodule

// File: source/sdramPhy.sv
// output registers for SDRAM pins, DQ drive and CPU handshake
// falling-edge read data latch
`timescale 1ns/1ps

module sdramPhy (
	input logic Clock,
	input logic Reset_L,
	input sdramPkg::sdramPins nextPins,
	input logic writeEnable,
	input logic [15:0] writeData,
	input logic latchRead,
	input logic ackNext,
	input logic initDone,
	input logic [15:0] DqIn,
	output sdramPkg::sdramPins SdramPins,
	output logic [15:0] DqOut,
	output logic DqEnable, // board buffer drives DQ when high
	output logic [15:0] DataOut, // read data to CPU
	output logic Dtack_L,
	output logic ResetOut_L
);

	////////////////////////////// pin registers
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			SdramPins.cmd <= sdramPkg::PowerUp; // CKE and CS low
			SdramPins.addr <= '0;
			SdramPins.bank <= 2'b00;
			DqEnable <= 1'b0;
			Dtack_L <= 1'b1;
			ResetOut_L <= 1'b0; // CPU held in reset until init ends
		end else begin
			SdramPins <= nextPins;
			DqEnable <= writeEnable;
			Dtack_L <= !ackNext;
			ResetOut_L <= initDone;
		end
	end

	// write data captured when the drive window opens
	always_ff @(posedge Clock) begin
		if (writeEnable && !DqEnable) DqOut <= writeData;
	end

	// read data mid-cycle, ahead of the Dtack edge
	always_ff @(negedge Clock) begin
		if (latchRead) DataOut <= DqIn;
	end

	noDriveOnRead: assert property (@(posedge Clock) disable iff (!Reset_L)
		!(DqEnable && SdramPins.cmd == sdramPkg::Read));

endmodule

// File: source/m68kDramCtrl.sv
// top level of the 68000 SDRAM controller
// timers, sequencer FSM and pin registers
`timescale 1ns/1ps
`include "m68kDram_macros.svh"

module m68kDramCtrl (
	input logic Clock,
	input logic Reset_L,
	input cpuBusPkg::cpuBus Bus,
	input logic [15:0] DqIn,
	output sdramPkg::sdramPins SdramPins,
	output logic [15:0] DqOut,
	output logic DqEnable,
	output logic [15:0] DataOut,
	output logic Dtack_L,
	output logic ResetOut_L
);

	logic delayLoad;
	logic [`TimerWidth-1:0] delayValue;
	logic refreshLoad;
	logic delayDone;
	logic refreshDue;
	sdramPkg::sdramPins nextPins; // command before the pin register
	logic writeEnable;
	logic [15:0] writeData;
	logic latchRead;
	logic ackNext;
	logic initDone;

	sdramTimers timersInst (.Clock, .Reset_L, .delayLoad, .delayValue, .refreshLoad,
		.delayDone, .refreshDue);

	dramSequencer sequencerInst (.Clock, .Reset_L, .Bus, .delayDone, .refreshDue,
		.delayLoad, .delayValue, .refreshLoad, .nextPins, .writeEnable, .writeData,
		.latchRead, .ackNext, .initDone);

	sdramPhy phyInst (.Clock, .Reset_L, .nextPins, .writeEnable, .writeData,
		.latchRead, .ackNext, .initDone, .DqIn, .SdramPins, .DqOut, .DqEnable,
		.DataOut, .Dtack_L, .ResetOut_L);

endmodule

// File: test/sdramModel.sv
// behavioral SDRAM for the controller testbench
// bank state, CAS latency read pipeline, init and refresh rule checks
`timescale 1ns/1ps
`include "m68kDram_macros.svh"

module sdramModel (
	input logic Clock,
	input sdramPkg::sdramPins Pins,
	input logic [15:0] Dq, // joined data bus
	input logic DqEnable, // controller drives Dq
	output logic [15:0] DqRead, // read data toward the controller
	output logic DqDrive,
	output logic InitOk, // precharge, refreshes and mode load seen in order
	output int RuleErrors,
	output int RefreshCount, // auto-refreshes after init
	output int MaxRefreshGap, // in cycles since init
	output sdramPkg::sdramPins LastAct, // most recent activate
	output sdramPkg::sdramPins LastCol // most recent read or write
);

	logic [15:0] mem [logic [24:0]]; // {bank, row, column}
	logic [12:0] openRow [4];
	logic [3:0] openBanks = '0;
	logic [`CasLatency-1:0] pipeValid = '0;
	logic [15:0] pipeData [`CasLatency];
	logic [24:0] key;
	logic sawPowerUp = 1'b0; // CKE seen low
	logic allPrecharged = 1'b0; // no activate since last precharge-all
	logic initFlag = 1'b0;
	int initRefreshes = 0;
	int refreshes = 0;
	int maxGap = 0;
	int lastRefresh = 0;
	int cycle = 0;
	int ruleErrs = 0;

	task automatic ruleCheck(input logic ok, input string what);
		assert (ok) else begin
			$display("SDRAM rule broken at %0t: %s", $time, what);
			ruleErrs++;
		end
	endtask

	////////////////////////////// command decode
	always @(posedge Clock) begin
		cycle++;
		for (int i = `CasLatency - 1; i > 0; i--) begin
			pipeValid[i] = pipeValid[i-1]; // read data moves toward DQ
			pipeData[i] = pipeData[i-1];
		end
		pipeValid[0] = 1'b0;
		key = {Pins.bank, openRow[Pins.bank], Pins.addr.colView.column};
		ruleCheck(!(DqEnable && DqDrive), "DQ driven by controller and SDRAM at once");
		case (Pins.cmd)
			sdramPkg::PowerUp: sawPowerUp = 1'b1;
			sdramPkg::Nop: ruleCheck(sawPowerUp, "NOP without CKE held low first");
			sdramPkg::Precharge: begin
				ruleCheck(Pins.addr.colView.autoPrecharge, "precharge of a single bank");
				openBanks = '0;
				allPrecharged = 1'b1;
			end
			sdramPkg::AutoRefresh: begin
				ruleCheck(openBanks == '0, "auto-refresh with a bank open");
				ruleCheck(allPrecharged, "auto-refresh without a precharge-all before it");
				if (initFlag) begin
					refreshes++;
					if (cycle - lastRefresh > maxGap) maxGap = cycle - lastRefresh;
				end else begin
					initRefreshes++; // init loop
				end
				lastRefresh = cycle;
			end
			sdramPkg::ModeSet: begin
				ruleCheck(initRefreshes == `InitRefreshCount,
					"mode load after a wrong number of init refreshes");
				ruleCheck(Pins.addr == `ModeRegisterValue, "wrong mode register value");
				initFlag = (initRefreshes == `InitRefreshCount) &&
					(Pins.addr == `ModeRegisterValue);
			end
			sdramPkg::Activate: begin
				ruleCheck(initFlag, "activate before mode register load");
				ruleCheck(!openBanks[Pins.bank], "activate of an open bank");
				openBanks[Pins.bank] = 1'b1;
				openRow[Pins.bank] = Pins.addr.rowView;
				allPrecharged = 1'b0;
				LastAct <= Pins;
			end
			sdramPkg::Write, sdramPkg::Read: begin
				ruleCheck(openBanks[Pins.bank], "access to a closed bank");
				ruleCheck(Pins.addr.colView.autoPrecharge, "access without auto-precharge");
				openBanks[Pins.bank] = 1'b0; // auto-precharge closes the row
				if (Pins.cmd == sdramPkg::Write) begin
					ruleCheck(DqEnable, "write without data driven on DQ");
					mem[key] = Dq;
				end else begin
					pipeValid[0] = 1'b1;
					pipeData[0] = mem.exists(key) ? mem[key] : 16'h0000;
				end
				LastCol <= Pins;
			end
			default: ;
		endcase
		DqDrive <= pipeValid[`CasLatency-1]; // valid across the CL edge
		DqRead <= pipeData[`CasLatency-1];
		InitOk <= initFlag;
		RuleErrors <= ruleErrs;
		RefreshCount <= refreshes;
		MaxRefreshGap <= maxGap;
	end

endmodule

// File: test/tbM68kDram.sv
// testbench for the 68000 SDRAM controller
// clock and reset, LCG stimulus, CPU bus driver, reference memory
// per-test result lines, watchdog and closing summary
`timescale 1ns/1ps
`include "m68kDram_macros.svh"

module tbM68kDram;

	localparam int AccessCount = 200; // random reads and writes
	localparam int MapCount = 16; // full-range addresses
	localparam int TermCount = 12; // accesses with held strobes
	localparam int InitBound = 200; // cycles until ResetOut_L rises
	localparam int AccessBound = 60; // cycles per access, refresh included
	localparam int IdleGap = 3 * `RefreshInterval;
	localparam int GapAllowance = 48; // one access on top of the refresh period
	localparam int DtackTimeout = 50;
	localparam int WatchdogMargin = 500;
	localparam int WatchdogCycles = 16 + InitBound + IdleGap + WatchdogMargin
		+ (AccessCount + 2 * MapCount + TermCount + 2) * AccessBound;

	logic Clock;
	logic Reset_L;
	cpuBusPkg::cpuBus Bus;
	logic [15:0] dqBus; // board buffer joins both directions
	sdramPkg::sdramPins SdramPins;
	logic [15:0] DqOut;
	logic DqEnable;
	logic [15:0] DataOut;
	logic Dtack_L;
	logic ResetOut_L;
	logic [15:0] modelDq;
	logic modelDrive;
	logic modelInitOk;
	int modelErrors;
	int modelRefreshes;
	int modelMaxGap;
	sdramPkg::sdramPins lastAct;
	sdramPkg::sdramPins lastCol;

	logic [31:0] randState = 32'h610a5d23;
	logic [15:0] refMem [logic [31:0]]; // expected contents by CPU address
	int errors = 0;
	int checks = 0;
	int tests = 0;

	assign dqBus = DqEnable ? DqOut : (modelDrive ? modelDq : 16'h0000);

	m68kDramCtrl m68kDramCtrl_inst (.Clock, .Reset_L, .Bus, .DqIn(dqBus), .SdramPins,
		.DqOut, .DqEnable, .DataOut, .Dtack_L, .ResetOut_L);

	sdramModel sdramModelInst (.Clock, .Pins(SdramPins), .Dq(dqBus), .DqEnable,
		.DqRead(modelDq), .DqDrive(modelDrive), .InitOk(modelInitOk),
		.RuleErrors(modelErrors), .RefreshCount(modelRefreshes),
		.MaxRefreshGap(modelMaxGap), .LastAct(lastAct), .LastCol(lastCol));

	initial begin
		Clock = 1'b0;
		forever #5 Clock = ~Clock;
	end

	initial begin
		#(WatchdogCycles * 10);
		$display("watchdog expired after %0d cycles, the run did not finish", WatchdogCycles);
		$display("TEST FAILED");
		$finish;
	end

	////////////////////////////// helpers
	function automatic logic [31:0] nextRandom();
		randState = randState * 32'd1664525 + 32'd1013904223;
		return randState;
	endfunction

	// small range unless fullRange with byte bit and top bits zero
	function automatic logic [31:0] makeAddress(input logic fullRange);
		logic [31:0] r;
		logic [31:0] a;
		r = nextRandom();
		a = 32'h0;
		a[25:24] = r[31:30]; // bank
		if (fullRange) begin
			a[23:11] = r[28:16];
			a[10:1] = r[15:6];
		end else begin
			a[13:11] = r[29:27]; // 8 rows
			a[4:1] = r[26:23]; // 16 columns
		end
		return a;
	endfunction

	function automatic int totalErrors();
		return errors + modelErrors;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		assert (got === expected) else begin
			$display("CHECK FAILED %s expected %h got %h", name, expected, got);
			errors++;
		end
	endtask

	task automatic reportTest(input string name, input int errorsBefore);
		tests++;
		$display("test %-12s %0d errors", name, totalErrors() - errorsBefore);
	endtask

	////////////////////////////// CPU bus driver
	task automatic runAccess(input logic isWrite, input logic [31:0] addrWord,
		input logic [15:0] wrData, input int holdCycles, output logic [15:0] rdData);
		int waitCount;
		@(posedge Clock);
		Bus.addr <= cpuBusPkg::cpuAddr'(addrWord);
		Bus.dataIn <= wrData;
		Bus.write_L <= !isWrite;
		Bus.select_L <= 1'b0;
		Bus.addrStrobe_L <= 1'b0;
		Bus.upperStrobe_L <= 1'b0; // both lanes since there are no byte writes
		Bus.lowerStrobe_L <= 1'b0;
		waitCount = 0;
		do begin
			@(posedge Clock);
			waitCount++;
		end while (Dtack_L && waitCount < DtackTimeout);
		assert (!Dtack_L) else begin
			$display("no Dtack_L within %0d cycles for address %h", DtackTimeout, addrWord);
			errors++;
		end
		rdData = DataOut; // valid from the first Dtack cycle
		for (int i = 0; i < holdCycles; i++) begin
			@(posedge Clock);
			checkValue("Dtack_L while strobes held", 32'(Dtack_L), 32'h0);
		end
		Bus.upperStrobe_L <= 1'b1; // lower strobe alone still holds the cycle
		@(posedge Clock);
		Bus.select_L <= 1'b1;
		Bus.addrStrobe_L <= 1'b1;
		Bus.lowerStrobe_L <= 1'b1;
		@(posedge Clock);
		checkValue("Dtack_L with one strobe held", 32'(Dtack_L), 32'h0);
		waitCount = 0;
		do begin
			@(posedge Clock);
			waitCount++;
		end while (!Dtack_L && waitCount < 4);
		assert (Dtack_L) else begin
			$display("Dtack_L still low after the strobes were released");
			errors++;
		end
	endtask

	task automatic checkMapping(input logic [31:0] addrWord);
		checkValue("Activate bank", 32'(lastAct.bank), 32'(addrWord[25:24]));
		checkValue("Activate row", 32'(lastAct.addr.rowView), 32'(addrWord[23:11]));
		checkValue("column", 32'(lastCol.addr.colView.column), 32'(addrWord[10:1]));
		checkValue("A10", 32'(lastCol.addr.colView.autoPrecharge), 32'h1);
		checkValue("column bank", 32'(lastCol.bank), 32'(addrWord[25:24]));
	endtask

	task automatic checkedAccess(input logic isWrite, input logic [31:0] addrWord,
		input int holdCycles);
		logic [31:0] r;
		logic [15:0] rdData;
		r = nextRandom();
		runAccess(isWrite, addrWord, r[31:16], holdCycles, rdData);
		checkMapping(addrWord);
		if (isWrite) begin
			refMem[addrWord] = r[31:16];
		end else begin
			checkValue("DataOut", 32'(rdData), 32'(refMem[addrWord]));
		end
	endtask

	////////////////////////////// test sequence
	initial begin
		logic [31:0] r;
		logic [31:0] addrWord;
		logic [31:0] mapAddr [MapCount];
		int errorsBefore;
		int baseRefreshes;
		int waitCount;
		Reset_L = 1'b0;
		Bus = '1; // strobes, select and AS inactive
		Bus.addr = '0;
		Bus.dataIn = '0;
		repeat (16) @(posedge Clock);
		Reset_L <= 1'b1;

		errorsBefore = totalErrors();
		waitCount = 0;
		while (!ResetOut_L && waitCount < InitBound) begin
			@(posedge Clock);
			waitCount++;
		end
		assert (ResetOut_L) else begin
			$display("ResetOut_L not released within %0d cycles", InitBound);
			errors++;
		end
		checkValue("model InitOk at ResetOut_L rise", 32'(modelInitOk), 32'h1);
		reportTest("init", errorsBefore);

		errorsBefore = totalErrors();
		addrWord = makeAddress(1'b0);
		checkedAccess(1'b1, addrWord, 0);
		checkedAccess(1'b0, addrWord, 0);
		reportTest("write-read", errorsBefore);

		errorsBefore = totalErrors();
		for (int i = 0; i < MapCount; i++) begin
			mapAddr[i] = makeAddress(1'b1); // every address bit exercised
			checkedAccess(1'b1, mapAddr[i], 0);
		end
		for (int i = 0; i < MapCount; i++) begin
			checkedAccess(1'b0, mapAddr[i], 0);
		end
		reportTest("mapping", errorsBefore);

		errorsBefore = totalErrors();
		for (int i = 0; i < AccessCount; i++) begin
			r = nextRandom();
			addrWord = makeAddress(1'b0);
			repeat (r[31:30]) @(posedge Clock); // idle gap
			checkedAccess(r[29] || !refMem.exists(addrWord), addrWord, int'(r[27:26]));
		end
		reportTest("random", errorsBefore);

		errorsBefore = totalErrors();
		for (int i = 0; i < TermCount; i++) begin
			r = nextRandom();
			addrWord = makeAddress(1'b0);
			checkedAccess(r[31] || !refMem.exists(addrWord), addrWord, 4 + int'(r[27:24]));
		end
		reportTest("termination", errorsBefore);

		errorsBefore = totalErrors();
		baseRefreshes = modelRefreshes;
		repeat (IdleGap) @(posedge Clock); // long idle with refresh only
		checks += 2;
		assert (modelRefreshes - baseRefreshes >= 2) else begin
			$display("CHECK FAILED refresh count expected at least %h got %h", 2,
				modelRefreshes - baseRefreshes);
			errors++;
		end
		assert (modelMaxGap <= `RefreshInterval + GapAllowance) else begin
			$display("CHECK FAILED MaxRefreshGap limit %h got %h",
				`RefreshInterval + GapAllowance, modelMaxGap);
			errors++;
		end
		reportTest("refresh", errorsBefore);

		$display("%0d tests, %0d checks, %0d errors", tests, checks, totalErrors());
		if (totalErrors() == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: m68kDram.f
+incdir+source
source/sdramPkg.sv
source/cpuBusPkg.sv
source/sdramTimers.sv
source/dramSequencer.sv
source/sdramPhy.sv
source/m68kDramCtrl.sv
test/sdramModel.sv
test/tbM68kDram.sv

// File: runSim.sh
#!/bin/bash
# build the testbench with Verilator, run it, judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tbM68kDram -f m68kDram.f -o simTb \
	> build.log 2>&1 \
	&& ./obj_dir/simTb > sim.log 2>&1 \
	|| echo "build or simulation stopped early, see build.log" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || grep -q "TEST PASSED" sim.log || exit 1
